/* dv/stateManagerTests.svh */
`ifndef STATE_MANAGER_TESTS_SVH
`define STATE_MANAGER_TESTS_SVH

// nothing fetched or saved so ip save leads straight to the alu
task automatic chainOrder();
  path = '{seqPkg::WriteRegIp, seqPkg::AluBegin, seqPkg::AluResults, seqPkg::WritePrep,
           seqPkg::FinishBegin};
  runCmd(makeCmd(1, 2, 3, 4, 3, 3, 3, 3, 0, 0, 0, 0), '0, 1'b0, 1'b0, 1'b0, 1'b1);
endtask

// cond on ip is saved back so the ip save is skipped
task automatic ipSaveOrder();
  // pointer follow-ups for cond and src0 and dst through its pointer
  path = '{seqPkg::FillCond, seqPkg::ReadCondP, seqPkg::ReadSrc1, seqPkg::ReadSrc0,
           seqPkg::ReadSrc0P, seqPkg::ReadDst, seqPkg::AluBegin, seqPkg::AluResults,
           seqPkg::WritePrep, seqPkg::WriteDstP, seqPkg::WriteCond, seqPkg::WriteSrc1,
           seqPkg::WriteSrc0, seqPkg::FinishBegin};
  runCmd(makeCmd(15, 2, 3, 4, 1, 1, 2, 3, 1, 0, 1, 1), 32'd5, 1'b0, 1'b0, 1'b0, 1'b0);
  checkFlag(dPtrSaveAllowed, 1'b1, "dPtrSaveAllowed");
  checkFlag(condSaveAllowed, 1'b1, "condSaveAllowed");
endtask

task automatic fillChoice();
  // src1 reuses captured cond and dst reuses captured src0
  path = '{seqPkg::WriteRegIp, seqPkg::ReadCond, seqPkg::FillSrc1, seqPkg::ReadSrc1P,
           seqPkg::ReadSrc0, seqPkg::FillDstP, seqPkg::AluBegin, seqPkg::AluResults,
           seqPkg::WritePrep, seqPkg::FinishBegin};
  runCmd(makeCmd(5, 5, 6, 6, 0, 0, 0, 3, 0, 1, 0, 1), '0, 1'b1, 1'b0, 1'b1, 1'b1);
  // same command with nothing captured reads every operand
  path = '{seqPkg::WriteRegIp, seqPkg::ReadCond, seqPkg::ReadSrc1, seqPkg::ReadSrc1P,
           seqPkg::ReadSrc0, seqPkg::ReadDst, seqPkg::AluBegin, seqPkg::AluResults,
           seqPkg::WritePrep, seqPkg::FinishBegin};
  runCmd(makeCmd(5, 5, 6, 6, 0, 0, 0, 3, 0, 1, 0, 1), '0, 1'b0, 1'b0, 1'b0, 1'b1);
  // zero cond blocks the pointer save
  checkFlag(dPtrSaveAllowed, 1'b0, "dPtrSaveAllowed");
endtask

// odd dst flags give the register write after the pointer write
task automatic writebackOrder();
  path = '{seqPkg::WriteRegIp, seqPkg::ReadSrc1, seqPkg::ReadSrc0, seqPkg::ReadDst,
           seqPkg::AluBegin, seqPkg::AluResults, seqPkg::WritePrep, seqPkg::WriteDstP,
           seqPkg::WriteDst, seqPkg::WriteSrc0, seqPkg::FinishBegin};
  // zero cond still saves dst since there is no condition operand
  runCmd(makeCmd(0, 3, 8, 3, 3, 1, 2, 1, 0, 0, 0, 1), '0, 1'b0, 1'b0, 1'b0, 1'b1);
  checkFlag(dSaveAllowed, 1'b1, "dSaveAllowed");
  // src1 loses register 3 to dst
  checkFlag(src1SaveAllowed, 1'b0, "src1SaveAllowed");
  checkFlag(src0SaveAllowed, 1'b1, "src0SaveAllowed");
endtask

task automatic savePermission();
  int cn, s1n, s0n, dn, cf, s1f, s0f, df, dp;
  logic condOk, expD, expC, exp1, exp0;
  logic [15:0] taken;
  for (int i = 0; i < RandomSteps; i++) begin
    cn = pickReg();
    s1n = pickReg();
    s0n = pickReg();
    dn = pickReg();
    cf = $urandom % 4;
    s1f = $urandom % 4;
    s0f = $urandom % 4;
    df = $urandom % 4;
    dp = $urandom % 2;
    cmdNext = makeCmd(cn, s1n, s0n, dn, cf, s1f, s0f, df, $urandom % 2, $urandom % 2,
                      $urandom % 2, dp);
    condNext = ($urandom % 2 == 0) ? '0 : $urandom;
    stepAny();
    condOk = (cf == 3) || (condNext != '0);
    expD = (df != 3) && condOk;
    // registers claimed in priority order dst, cond, src1, src0
    taken = '0;
    if (expD) taken[4'(dn)] = 1'b1;
    expC = (^2'(cf)) && !taken[4'(cn)];
    if (expC) taken[4'(cn)] = 1'b1;
    exp1 = (^2'(s1f)) && !taken[4'(s1n)];
    if (exp1) taken[4'(s1n)] = 1'b1;
    exp0 = (^2'(s0f)) && !taken[4'(s0n)];
    if (exp0) taken[4'(s0n)] = 1'b1;
    checkFlag(dSaveAllowed, expD, "dSaveAllowed");
    checkFlag(dPtrSaveAllowed, (df == 3) && (dp != 0) && condOk, "dPtrSaveAllowed");
    checkFlag(condSaveAllowed, expC, "condSaveAllowed");
    checkFlag(src1SaveAllowed, exp1, "src1SaveAllowed");
    checkFlag(src0SaveAllowed, exp0, "src0SaveAllowed");
    checkFlag(ipSaveAllowed, !taken[IpRegNum], "ipSaveAllowed");
  end
endtask

`endif

/* dv/stateManagerTb.sv */
`timescale 1ns/1ps

module stateManagerTb;

  localparam int DataWidth = 32;
  localparam int IpRegNum = 15;
  localparam int ClkPeriod = 8;
  localparam int RandomSteps = 24;
  // reset, chains, ip save, two fill runs, writeback order and the random flag steps
  localparam int TestEdges = 3 + 13 + 22 + 36 + 19 + RandomSteps;
  localparam int MarginEdges = 16;

  logic next_state, rst, condRead, src1Read, src0Read;
  seqPkg::command_t command;
  logic [DataWidth-1:0] cond;
  seqPkg::seqState_t state;
  logic stepAck, ipSaveAllowed, dSaveAllowed, dPtrSaveAllowed;
  logic condSaveAllowed, src1SaveAllowed, src0SaveAllowed;

  // inputs applied on the next rising edge
  seqPkg::command_t cmdNext;
  logic [DataWidth-1:0] condNext;
  logic condReadNext, src1ReadNext, src0ReadNext;
  // ack level expected after each step
  logic ackExp;
  // states expected between Preexecute and FinishEnd
  seqPkg::seqState_t path[$];
  int unsigned seed;

  stateManager #(.DataWidth(DataWidth), .IpRegNum(IpRegNum)) dut (.*);

  always #(ClkPeriod / 2) next_state = ~next_state;

  // hard stop if the sequence never gets back
  initial begin
    #(ClkPeriod * (TestEdges + MarginEdges));
    $display("sim failed");
    $fatal(1, "timeout, the tests did not finish within %0d edges", TestEdges + MarginEdges);
  end

  task automatic checkState(input seqPkg::seqState_t got, input seqPkg::seqState_t exp,
                            input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %s, expected %s", $time, what, got.name(),
               exp.name());
      $display("sim failed");
      $fatal(1, "wrong sequencer state");
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "wrong flag value");
    end
  endtask

  // arguments in cond src1 src0 dst order for numbers, flags and pointer bits
  function automatic seqPkg::command_t makeCmd(input int cn, s1n, s0n, dn,
                                               input int cf, s1f, s0f, df,
                                               input int cp, s1p, s0p, dp);
    seqPkg::command_t c;
    c = '0;
    c[seqPkg::CondNumLsb +: 4] = 4'(cn);
    c[seqPkg::Src1NumLsb +: 4] = 4'(s1n);
    c[seqPkg::Src0NumLsb +: 4] = 4'(s0n);
    c[seqPkg::DstNumLsb +: 4] = 4'(dn);
    c[seqPkg::CondFlagsLsb +: 2] = 2'(cf);
    c[seqPkg::Src1FlagsLsb +: 2] = 2'(s1f);
    c[seqPkg::Src0FlagsLsb +: 2] = 2'(s0f);
    c[seqPkg::DstFlagsLsb +: 2] = 2'(df);
    c[seqPkg::CondPtrBit] = (cp != 0);
    c[seqPkg::Src1PtrBit] = (s1p != 0);
    c[seqPkg::Src0PtrBit] = (s0p != 0);
    c[seqPkg::DstPtrBit] = (dp != 0);
    return c;
  endfunction

  // small range so registers collide with ip mixed in
  function automatic int pickReg();
    int r;
    r = $urandom % 4;
    return (r == 3) ? IpRegNum : r;
  endfunction

  // one strobe edge and one ack flip per call
  task automatic stepAny();
    @(posedge next_state);
    command <= cmdNext;
    cond <= condNext;
    condRead <= condReadNext;
    src1Read <= src1ReadNext;
    src0Read <= src0ReadNext;
    ackExp = ~ackExp;
    @(negedge next_state);
    checkFlag(stepAck, ackExp, "stepAck");
  endtask

  task automatic step(input seqPkg::seqState_t exp);
    stepAny();
    checkState(state, exp, "state");
  endtask

  // full instruction from idle back to idle
  task automatic runCmd(input seqPkg::command_t c, input logic [DataWidth-1:0] cnd,
                        input logic cr, input logic s1r, input logic s0r,
                        input logic expIp);
    cmdNext = c;
    condNext = cnd;
    condReadNext = cr;
    src1ReadNext = s1r;
    src0ReadNext = s0r;
    step(seqPkg::StartBegin);
    step(seqPkg::ReadMemSize1);
    step(seqPkg::AfterMemSizeRead);
    step(seqPkg::StartReadCmd);
    step(seqPkg::StartReadCmdP);
    step(seqPkg::Preexecute);
    checkFlag(ipSaveAllowed, expIp, "ipSaveAllowed");
    foreach (path[i]) begin
      step(path[i]);
    end
    step(seqPkg::FinishEnd);
    step(seqPkg::WaitForStart);
  endtask

  `include "stateManagerTests.svh"

  initial begin
    seed = $urandom(32'h99bba15f);
    next_state = 1'b0;
    rst = 1'b1;
    command = '0;
    cond = '0;
    condRead = 1'b0;
    src1Read = 1'b0;
    src0Read = 1'b0;
    cmdNext = '0;
    condNext = '0;
    condReadNext = 1'b0;
    src1ReadNext = 1'b0;
    src0ReadNext = 1'b0;
    ackExp = 1'b0;
    repeat (3) @(posedge next_state);
    rst <= 1'b0;
    @(negedge next_state);
    checkState(state, seqPkg::WaitForStart, "state after reset");
    checkFlag(stepAck, 1'b0, "stepAck after reset");
    chainOrder();
    ipSaveOrder();
    fillChoice();
    writebackOrder();
    savePermission();
    $display("sim passed");
    $finish;
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module stateManagerTb -o simv
output=$(./obj_dir/simv 2>&1 || true)
echo "$output"
if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* src/instructionSequencer.sv */
`timescale 1ns/1ps

module instructionSequencer (
  input  logic              next_state,
  input  logic              rst,
  input  seqPkg::seqState_t fetchNext,
  input  seqPkg::seqState_t writeNext,
  input  logic              ipSaveAllowed,
  output seqPkg::seqState_t state,
  output logic              stepAck
);

  seqPkg::seqState_t stateNext;

  // next state from the fixed chains and the planners
  always_comb begin
    case (state)
      // startup chain
      seqPkg::WaitForStart: stateNext = seqPkg::StartBegin;
      seqPkg::StartBegin: stateNext = seqPkg::ReadMemSize1;
      seqPkg::ReadMemSize1: stateNext = seqPkg::AfterMemSizeRead;
      seqPkg::AfterMemSizeRead: stateNext = seqPkg::StartReadCmd;
      seqPkg::StartReadCmd: stateNext = seqPkg::StartReadCmdP;
      seqPkg::StartReadCmdP: stateNext = seqPkg::Preexecute;

      // ip save comes before any operand fetch
      seqPkg::Preexecute: begin
        if (ipSaveAllowed) begin
          stateNext = seqPkg::WriteRegIp;
        end else begin
          stateNext = fetchNext;
        end
      end

      // fetch points, order picked by the fetch planner
      seqPkg::WriteRegIp,
      seqPkg::ReadCond,
      seqPkg::FillCond,
      seqPkg::ReadCondP,
      seqPkg::ReadSrc1,
      seqPkg::FillSrc1,
      seqPkg::ReadSrc1P,
      seqPkg::ReadSrc0,
      seqPkg::FillSrc0,
      seqPkg::ReadSrc0P,
      seqPkg::ReadDst,
      seqPkg::FillDstP: stateNext = fetchNext;

      // alu chain
      seqPkg::AluBegin: stateNext = seqPkg::AluResults;
      seqPkg::AluResults: stateNext = seqPkg::WritePrep;

      // writeback order from the writeback planner
      seqPkg::WritePrep,
      seqPkg::WriteDstP,
      seqPkg::WriteDst,
      seqPkg::WriteCond,
      seqPkg::WriteSrc1,
      seqPkg::WriteSrc0: stateNext = writeNext;

      // finish chain, back to idle
      seqPkg::FinishBegin: stateNext = seqPkg::FinishEnd;
      seqPkg::FinishEnd: stateNext = seqPkg::WaitForStart;

      // unused codes recover to idle
      default: stateNext = seqPkg::WaitForStart;
    endcase
  end

  // one step per strobe edge
  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      state <= seqPkg::WaitForStart;
      stepAck <= 1'b0;
    end else begin
      state <= stateNext;
      // ack flips on every step, no exceptions
      stepAck <= ~stepAck;
    end
  end

endmodule

/* src/operandFetchPlanner.sv */
`timescale 1ns/1ps

module operandFetchPlanner #(
  parameter int IpRegNum = 15
) (
  input  seqPkg::seqState_t state,
  input  seqPkg::command_t  command,
  input  logic              condRead,
  input  logic              src1Read,
  input  logic              src0Read,
  output seqPkg::seqState_t fetchNext
);

  localparam seqPkg::regNum_t IpReg = seqPkg::regNum_t'(IpRegNum);
  localparam int NumW = $bits(seqPkg::regNum_t);
  localparam int FlagW = $bits(seqPkg::regFlags_t);

  // operand fields
  seqPkg::regNum_t condNum, src1Num, src0Num, dstNum;
  seqPkg::regFlags_t condFlags, src1Flags, src0Flags;
  logic condPtr, src1Ptr, src0Ptr, dstPtr;
  // operand is fetched at all
  logic condUsed, src1Used, src0Used;
  // fill instead of a register read
  logic src1Fill, src0Fill, dstFill;
  // next fetch once the named operand is done
  seqPkg::seqState_t afterCond, afterSrc1, afterSrc0, fromStart;

  assign condNum = command[seqPkg::CondNumLsb +: NumW];
  assign src1Num = command[seqPkg::Src1NumLsb +: NumW];
  assign src0Num = command[seqPkg::Src0NumLsb +: NumW];
  assign dstNum = command[seqPkg::DstNumLsb +: NumW];
  assign condFlags = command[seqPkg::CondFlagsLsb +: FlagW];
  assign src1Flags = command[seqPkg::Src1FlagsLsb +: FlagW];
  assign src0Flags = command[seqPkg::Src0FlagsLsb +: FlagW];
  assign condPtr = command[seqPkg::CondPtrBit];
  assign src1Ptr = command[seqPkg::Src1PtrBit];
  assign src0Ptr = command[seqPkg::Src0PtrBit];
  assign dstPtr = command[seqPkg::DstPtrBit];

  assign condUsed = (condFlags != 2'b11);
  assign src1Used = (src1Flags != 2'b11);
  assign src0Used = (src0Flags != 2'b11);

  // fill from ip, or reuse a value captured by an earlier read
  assign src1Fill = (src1Num == IpReg)
    || (condUsed && src1Num == condNum && condRead);
  assign src0Fill = (src0Num == IpReg)
    || (condUsed && src0Num == condNum && condRead)
    || (src1Used && src0Num == src1Num && src1Read);
  assign dstFill = (dstNum == IpReg)
    || (condUsed && dstNum == condNum && condRead)
    || (src1Used && dstNum == src1Num && src1Read)
    || (src0Used && dstNum == src0Num && src0Read);

  // destination only fetched through its pointer
  assign afterSrc0 = !dstPtr ? seqPkg::AluBegin
    : (dstFill ? seqPkg::FillDstP : seqPkg::ReadDst);
  assign afterSrc1 = !src0Used ? afterSrc0
    : (src0Fill ? seqPkg::FillSrc0 : seqPkg::ReadSrc0);
  assign afterCond = !src1Used ? afterSrc1
    : (src1Fill ? seqPkg::FillSrc1 : seqPkg::ReadSrc1);
  // nothing captured before cond, ip is the only fill source
  assign fromStart = !condUsed ? afterCond
    : ((condNum == IpReg) ? seqPkg::FillCond : seqPkg::ReadCond);

  always_comb begin
    case (state)
      seqPkg::Preexecute, seqPkg::WriteRegIp: fetchNext = fromStart;
      // pointer follow-up read first
      seqPkg::ReadCond, seqPkg::FillCond:
        fetchNext = condPtr ? seqPkg::ReadCondP : afterCond;
      seqPkg::ReadCondP: fetchNext = afterCond;
      seqPkg::ReadSrc1, seqPkg::FillSrc1:
        fetchNext = src1Ptr ? seqPkg::ReadSrc1P : afterSrc1;
      seqPkg::ReadSrc1P: fetchNext = afterSrc1;
      seqPkg::ReadSrc0, seqPkg::FillSrc0:
        fetchNext = src0Ptr ? seqPkg::ReadSrc0P : afterSrc0;
      seqPkg::ReadSrc0P: fetchNext = afterSrc0;
      // dst is the last fetch
      default: fetchNext = seqPkg::AluBegin;
    endcase
  end

endmodule

/* src/seqPkg.sv */
package seqPkg;

  // command field positions
  // register numbers, one nibble per operand
  localparam int Src1NumLsb = 0;
  localparam int Src0NumLsb = 4;
  localparam int DstNumLsb = 8;
  localparam int CondNumLsb = 12;

  // pointer bits, an operand is an address when set
  localparam int Src1PtrBit = 16;
  localparam int Src0PtrBit = 17;
  localparam int DstPtrBit = 18;
  localparam int CondPtrBit = 19;

  // access flags, two bits per operand
  localparam int Src1FlagsLsb = 20;
  localparam int Src0FlagsLsb = 22;
  localparam int DstFlagsLsb = 24;
  localparam int CondFlagsLsb = 26;

  // opcode sits in the top nibble
  localparam int OpcodeLsb = 28;

  typedef logic [3:0] regNum_t;
  // 11 means operand not read, odd parity means written back
  typedef logic [1:0] regFlags_t;
  typedef logic [3:0] opcode_t;

  // opcode is the last field, so it closes the word
  localparam int CommandWidth = OpcodeLsb + $bits(opcode_t);
  typedef logic [CommandWidth-1:0] command_t;

  typedef enum logic [5:0] {
    // startup chain
    WaitForStart, StartBegin, ReadMemSize1, AfterMemSizeRead,
    StartReadCmd, StartReadCmdP, Preexecute,
    // ip save
    WriteRegIp,
    // operand fetch
    ReadCond, FillCond, ReadCondP,
    ReadSrc1, FillSrc1, ReadSrc1P,
    ReadSrc0, FillSrc0, ReadSrc0P,
    ReadDst, FillDstP,
    // alu
    AluBegin, AluResults,
    // writeback
    WritePrep, WriteDstP, WriteDst, WriteCond, WriteSrc1, WriteSrc0,
    // finish chain
    FinishBegin, FinishEnd
  } seqState_t;

endpackage

/* src/stateManager.sv */
`timescale 1ns/1ps

module stateManager #(
  parameter int DataWidth = 32,
  parameter int IpRegNum = 15
) (
  input  logic                 next_state,
  input  logic                 rst,
  input  seqPkg::command_t     command,
  input  logic [DataWidth-1:0] cond,
  input  logic                 condRead,
  input  logic                 src1Read,
  input  logic                 src0Read,
  output seqPkg::seqState_t    state,
  output logic                 stepAck,
  output logic                 ipSaveAllowed,
  output logic                 dSaveAllowed,
  output logic                 dPtrSaveAllowed,
  output logic                 condSaveAllowed,
  output logic                 src1SaveAllowed,
  output logic                 src0SaveAllowed
);

  // planner results into the state register
  seqPkg::seqState_t fetchNext;
  seqPkg::seqState_t writeNext;

  // fetch order and read or fill choice
  operandFetchPlanner #(
    .IpRegNum(IpRegNum)
  ) fetchPlanner (
    .state(state),
    .command(command),
    .condRead(condRead),
    .src1Read(src1Read),
    .src0Read(src0Read),
    .fetchNext(fetchNext)
  );

  // save permissions and writeback order
  writebackPlanner #(
    .DataWidth(DataWidth),
    .IpRegNum(IpRegNum)
  ) writePlanner (
    .state(state),
    .command(command),
    .cond(cond),
    .writeNext(writeNext),
    .ipSaveAllowed(ipSaveAllowed),
    .dSaveAllowed(dSaveAllowed),
    .dPtrSaveAllowed(dPtrSaveAllowed),
    .condSaveAllowed(condSaveAllowed),
    .src1SaveAllowed(src1SaveAllowed),
    .src0SaveAllowed(src0SaveAllowed)
  );

  instructionSequencer sequencer (
    .next_state(next_state),
    .rst(rst),
    .fetchNext(fetchNext),
    .writeNext(writeNext),
    .ipSaveAllowed(ipSaveAllowed),
    .state(state),
    .stepAck(stepAck)
  );

endmodule

/* src/writebackPlanner.sv */
`timescale 1ns/1ps

module writebackPlanner #(
  parameter int DataWidth = 32,
  parameter int IpRegNum = 15
) (
  input  seqPkg::seqState_t      state,
  input  seqPkg::command_t       command,
  input  logic [DataWidth-1:0]   cond,
  output seqPkg::seqState_t      writeNext,
  output logic                   ipSaveAllowed,
  output logic                   dSaveAllowed,
  output logic                   dPtrSaveAllowed,
  output logic                   condSaveAllowed,
  output logic                   src1SaveAllowed,
  output logic                   src0SaveAllowed
);

  localparam seqPkg::regNum_t IpReg = seqPkg::regNum_t'(IpRegNum);
  localparam int NumW = $bits(seqPkg::regNum_t);
  localparam int FlagW = $bits(seqPkg::regFlags_t);

  seqPkg::regNum_t condNum, src1Num, src0Num, dstNum;
  seqPkg::regFlags_t condFlags, src1Flags, src0Flags, dstFlags;
  logic dstPtr;
  // condition passes, or no condition operand at all
  logic condOk;
  // remaining order after each writer
  seqPkg::seqState_t afterDst, afterCond, afterSrc1;

  assign condNum = command[seqPkg::CondNumLsb +: NumW];
  assign src1Num = command[seqPkg::Src1NumLsb +: NumW];
  assign src0Num = command[seqPkg::Src0NumLsb +: NumW];
  assign dstNum = command[seqPkg::DstNumLsb +: NumW];
  assign condFlags = command[seqPkg::CondFlagsLsb +: FlagW];
  assign src1Flags = command[seqPkg::Src1FlagsLsb +: FlagW];
  assign src0Flags = command[seqPkg::Src0FlagsLsb +: FlagW];
  assign dstFlags = command[seqPkg::DstFlagsLsb +: FlagW];
  assign dstPtr = command[seqPkg::DstPtrBit];

  assign condOk = (condFlags == 2'b11) || (cond != '0);

  // dst into register, or through its pointer when flags are 11
  assign dSaveAllowed = (dstFlags != 2'b11) && condOk;
  assign dPtrSaveAllowed = (dstFlags == 2'b11) && dstPtr && condOk;

  // one write slot per register, higher priority writer keeps it
  assign condSaveAllowed = (^condFlags)
    && !(dSaveAllowed && dstNum == condNum);
  assign src1SaveAllowed = (^src1Flags)
    && !(dSaveAllowed && dstNum == src1Num)
    && !(condSaveAllowed && condNum == src1Num);
  assign src0SaveAllowed = (^src0Flags)
    && !(dSaveAllowed && dstNum == src0Num)
    && !(condSaveAllowed && condNum == src0Num)
    && !(src1SaveAllowed && src1Num == src0Num);

  // ip only saved when no operand overwrites it
  assign ipSaveAllowed = !((dSaveAllowed && dstNum == IpReg)
    || (condSaveAllowed && condNum == IpReg)
    || (src1SaveAllowed && src1Num == IpReg)
    || (src0SaveAllowed && src0Num == IpReg));

  assign afterSrc1 = src0SaveAllowed ? seqPkg::WriteSrc0 : seqPkg::FinishBegin;
  assign afterCond = src1SaveAllowed ? seqPkg::WriteSrc1 : afterSrc1;
  assign afterDst = condSaveAllowed ? seqPkg::WriteCond : afterCond;

  always_comb begin
    case (state)
      seqPkg::WritePrep: begin
        if (dSaveAllowed || dPtrSaveAllowed) begin
          writeNext = dstPtr ? seqPkg::WriteDstP : seqPkg::WriteDst;
        end else begin
          writeNext = afterDst;
        end
      end
      // pointer write then register write for odd flags
      seqPkg::WriteDstP: writeNext = (^dstFlags) ? seqPkg::WriteDst : afterDst;
      seqPkg::WriteDst: writeNext = afterDst;
      seqPkg::WriteCond: writeNext = afterCond;
      seqPkg::WriteSrc1: writeNext = afterSrc1;
      default: writeNext = seqPkg::FinishBegin;
    endcase
  end

endmodule

/* vlog.f */
+incdir+dv
src/seqPkg.sv
src/operandFetchPlanner.sv
src/writebackPlanner.sv
src/instructionSequencer.sv
src/stateManager.sv
dv/stateManagerTb.sv
